//--- src.f
+incdir+include
verilog/cpuTypesPkg.sv
verilog/agenTypesPkg.sv
verilog/agenStation.sv
verilog/agenUnit.sv
verilog/agenTop.sv
testbench/agenChecker.sv
testbench/agenTb.sv

//--- run.sh
#!/bin/sh
# Build the address-generation testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module agenTb -o agenSim \
	&& ./obj_dir/agenSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^TEST PASSED$" sim.log \
	&& exit 0 \
	|| exit 1

//--- testbench/agenTb.sv
// ================================================
// Address-generation testbench
// Applies a table of memory ops with snoops and
// memory stalls, then reports the checker's counts
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "agen_config.svh"

module agenTb;

	localparam int ROWS = 9;
	localparam int PERIOD = 40;

	logic clk;
	logic rst;
	logic issue;
	logic memReady;
	logic reqValid;
	logic stationIdle;
	logic expFast;
	agenTypesPkg::issueBundle_t bundle;
	agenTypesPkg::snoopPort_t [`AGEN_SNOOP_PORTS-1:0] snoop;
	agenTypesPkg::memRequest_t memRequest;
	agenTypesPkg::memRequest_t expReq;
	int checked;
	int errors;
	int stallReq;
	int watchLimit;
	logic tableReady;

	// ================================================
	// Stimulus table with one row per op
	// ================================================
	agenTypesPkg::issueBundle_t bundleTab [ROWS];
	// Per operand A, B, C a delay of 0 means no snoop
	int snDelay [ROWS][3];
	int snPort [ROWS][3];
	cpuTypesPkg::value_t snVal [ROWS][3];
	// An extra snoop event with delay 0 lands in the same cycle as operand B
	int xDelay [ROWS];
	int xPort [ROWS];
	cpuTypesPkg::pregno_t xPreg [ROWS];
	cpuTypesPkg::value_t xVal [ROWS];
	int bpTab [ROWS];
	logic fastTab [ROWS];
	agenTypesPkg::memRequest_t expTab [ROWS];

	agenTop u_dut (
		.clk           (clk),
		.rst           (rst),
		.issue_i       (issue),
		.issueBundle_i (bundle),
		.snoop_i       (snoop),
		.memReady_i    (memReady),
		.stationIdle_o (stationIdle),
		.reqValid_o    (reqValid),
		.memRequest_o  (memRequest)
	);

	agenChecker u_checker (
		.clk           (clk),
		.rst           (rst),
		.issue_i       (issue),
		.stationIdle_i (stationIdle),
		.expReq_i      (expReq),
		.expFast_i     (expFast),
		.reqValid_i    (reqValid),
		.memReady_i    (memReady),
		.memRequest_i  (memRequest),
		.checked_o     (checked),
		.errors_o      (errors)
	);

	function automatic agenTypesPkg::srcOperand_t mkSrc(int preg, logic ready,
		cpuTypesPkg::value_t v);
		agenTypesPkg::srcOperand_t s;
		s.preg = cpuTypesPkg::pregno_t'(preg);
		s.ready = ready;
		s.value = v;
		return s;
	endfunction

	function automatic agenTypesPkg::issueBundle_t mkBundle(int rob, agenTypesPkg::memOp_t op,
		agenTypesPkg::srcOperand_t a, agenTypesPkg::srcOperand_t b,
		agenTypesPkg::srcOperand_t c, int scale, logic [11:0] imm, int dest);
		agenTypesPkg::issueBundle_t ib;
		ib.robNdx = cpuTypesPkg::robNdx_t'(rob);
		ib.memOp = op;
		ib.srcA = a;
		ib.srcB = b;
		ib.srcC = c;
		ib.scale = 2'(scale);
		ib.imm = imm;
		ib.dest = cpuTypesPkg::pregno_t'(dest);
		return ib;
	endfunction

	// Register 0 reads zero and a ready operand carries its own value
	// Every other operand takes the snooped value
	function automatic cpuTypesPkg::value_t opValue(agenTypesPkg::srcOperand_t s,
		cpuTypesPkg::value_t snooped);
		if (s.preg == 0)
			return 0;
		return s.ready ? s.value : snooped;
	endfunction

	function automatic agenTypesPkg::memRequest_t expectRequest(int r);
		agenTypesPkg::memRequest_t q;
		cpuTypesPkg::value_t a;
		cpuTypesPkg::value_t b;
		cpuTypesPkg::value_t c;
		int immS;
		a = opValue(bundleTab[r].srcA, snVal[r][0]);
		b = opValue(bundleTab[r].srcB, snVal[r][1]);
		c = opValue(bundleTab[r].srcC, snVal[r][2]);
		immS = int'($signed(bundleTab[r].imm));
		q.robNdx = bundleTab[r].robNdx;
		q.memOp = bundleTab[r].memOp;
		q.address = cpuTypesPkg::address_t'(a) + (cpuTypesPkg::address_t'(b)
			<< bundleTab[r].scale) + cpuTypesPkg::address_t'(immS);
		q.storeData = (bundleTab[r].memOp == agenTypesPkg::MEM_LOAD) ? '0 : c;
		q.dest = bundleTab[r].dest;
		return q;
	endfunction

	task automatic setSnoop(int r, int idx, int delay, int port, cpuTypesPkg::value_t v);
		snDelay[r][idx] = delay;
		snPort[r][idx] = port;
		snVal[r][idx] = v;
	endtask

	task automatic buildTable();
		int maxD;
		int maxBp;
		for (int r = 0; r < ROWS; r++) begin
			for (int i = 0; i < 3; i++)
				setSnoop(r, i, 0, 0, 0);
			xPort[r] = -1;
			xDelay[r] = 0;
			xPreg[r] = 0;
			xVal[r] = 0;
			bpTab[r] = 0;
			fastTab[r] = 1'b0;
		end
		bundleTab[0] = mkBundle(1, agenTypesPkg::MEM_LOAD, mkSrc(5, 1, 'h1000),
			mkSrc(6, 1, 'h10), mkSrc(7, 1, 'hdeadbeef), 2, 12'h004, 20);
		fastTab[0] = 1'b1;
		bundleTab[1] = mkBundle(2, agenTypesPkg::MEM_STORE, mkSrc(8, 1, 'h20000000),
			mkSrc(9, 1, 'h3), mkSrc(10, 1, 'hcafef00d), 0, 12'h7ff, 21);
		fastTab[1] = 1'b1;
		// Register 0 reads zero even with a nonzero snoop on it
		bundleTab[2] = mkBundle(3, agenTypesPkg::MEM_ATOMIC, mkSrc(0, 0, 'h55),
			mkSrc(11, 1, 'h40), mkSrc(0, 1, 'h99), 1, 12'h010, 22);
		fastTab[2] = 1'b1;
		xDelay[2] = 1;
		xPort[2] = 1;
		xVal[2] = 'h1234;
		bundleTab[3] = mkBundle(4, agenTypesPkg::MEM_LOAD, mkSrc(12, 0, 0),
			mkSrc(13, 0, 0), mkSrc(14, 1, 'h5), 3, 12'hff0, 23);
		setSnoop(3, 0, 2, 3, 'h2000);
		setSnoop(3, 1, 1, 0, 'h8);
		// The lower port wins over a same-cycle match on port 2 and the address wraps
		bundleTab[4] = mkBundle(5, agenTypesPkg::MEM_STORE, mkSrc(15, 1, 'h100),
			mkSrc(16, 0, 0), mkSrc(17, 0, 0), 1, 12'h800, 24);
		setSnoop(4, 1, 3, 0, 'h4);
		setSnoop(4, 2, 2, 1, 'h77);
		xPort[4] = 2;
		xPreg[4] = 16;
		xVal[4] = 'h999;
		// Stall so the next op waits in the station
		bundleTab[5] = mkBundle(6, agenTypesPkg::MEM_LOAD, mkSrc(18, 1, 'h4000),
			mkSrc(19, 1, 'h2), mkSrc(20, 1, 'h0), 2, 12'h000, 25);
		bpTab[5] = 6;
		bundleTab[6] = mkBundle(7, agenTypesPkg::MEM_STORE, mkSrc(21, 1, 'h5000),
			mkSrc(22, 1, 'h1), mkSrc(23, 1, 'habc), 3, 12'h0fc, 26);
		bundleTab[7] = mkBundle(8, agenTypesPkg::MEM_ATOMIC, mkSrc(24, 1, 'hfffffff0),
			mkSrc(25, 1, 'h10), mkSrc(26, 0, 0), 2, 12'h001, 27);
		setSnoop(7, 2, 1, 2, 'h1357);
		bpTab[7] = 3;
		bundleTab[8] = mkBundle(9, agenTypesPkg::MEM_LOAD, mkSrc(27, 1, 'h7000),
			mkSrc(28, 0, 0), mkSrc(29, 1, 'h1), 0, 12'hfff, 28);
		setSnoop(8, 1, 2, 3, 'h20);
		maxD = 0;
		maxBp = 0;
		for (int r = 0; r < ROWS; r++) begin
			expTab[r] = expectRequest(r);
			for (int i = 0; i < 3; i++)
				maxD = (snDelay[r][i] > maxD) ? snDelay[r][i] : maxD;
			maxBp = (bpTab[r] > maxBp) ? bpTab[r] : maxBp;
		end
		// Random jitter adds at most one cycle to the delay and to the stall
		// Reset adds eight more cycles
		watchLimit = ROWS * ((maxD + 1) + (maxBp + 1) + 10) + 8;
		tableReady = 1'b1;
	endtask

	// Issue one row once the station is free, then play its snoops
	task automatic applyRow(int r);
		int d[3];
		int xd;
		int maxD;
		do begin
			@(posedge clk);
			#1;
		end while (!stationIdle);
		issue = 1'b1;
		bundle = bundleTab[r];
		expReq = expTab[r];
		expFast = fastTab[r];
		stallReq = bpTab[r];
		maxD = 0;
		for (int i = 0; i < 3; i++) begin
			d[i] = (snDelay[r][i] == 0) ? 0 : snDelay[r][i] + int'($urandom % 2);
			maxD = (d[i] > maxD) ? d[i] : maxD;
		end
		xd = (xDelay[r] == 0) ? d[1] : xDelay[r];
		if (xPort[r] >= 0 && xd > maxD)
			maxD = xd;
		@(posedge clk);
		#1;
		issue = 1'b0;
		for (int cy = 1; cy <= maxD; cy++) begin
			snoop = '0;
			for (int i = 0; i < 3; i++) begin
				if (d[i] == cy) begin
					snoop[snPort[r][i]].valid = 1'b1;
					snoop[snPort[r][i]].preg = bundleTab[r].srcA.preg;
					if (i == 1)
						snoop[snPort[r][i]].preg = bundleTab[r].srcB.preg;
					if (i == 2)
						snoop[snPort[r][i]].preg = bundleTab[r].srcC.preg;
					snoop[snPort[r][i]].value = snVal[r][i];
				end
			end
			if (xPort[r] >= 0 && xd == cy) begin
				snoop[xPort[r]].valid = 1'b1;
				snoop[xPort[r]].preg = xPreg[r];
				snoop[xPort[r]].value = xVal[r];
			end
			@(posedge clk);
			#1;
		end
		snoop = '0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// The memory side is ready unless a row asked for a stall
	initial begin : memSide
		int left;
		memReady = 1'b1;
		left = 0;
		forever begin
			@(posedge clk);
			if (stallReq > 0) begin
				left = stallReq + int'($urandom % 2);
				stallReq = 0;
			end
			#1;
			if (left > 0) begin
				memReady = 1'b0;
				left--;
			end else begin
				memReady = 1'b1;
			end
		end
	end

	initial begin : watchdog
		wait (tableReady);
		repeat (watchLimit) @(posedge clk);
		$display("Run timed out waiting for the station or a request");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(25));
		rst = 1'b1;
		issue = 1'b0;
		bundle = '0;
		snoop = '0;
		expReq = '0;
		expFast = 1'b0;
		stallReq = 0;
		tableReady = 1'b0;
		buildTable();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int r = 0; r < ROWS; r++)
			applyRow(r);
		while (checked < ROWS)
			@(posedge clk);
		repeat (3) @(posedge clk);
		$display("ops %0d, checked %0d, errors %0d", ROWS, checked, errors);
		if (errors == 0 && checked == ROWS)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/agenChecker.sv
// ================================================
// Address-generation request checker
// Pairs each accepted request with the oldest issued
// op and compares fields, latency and stall behavior
// ================================================
`timescale 1ns/1ps
`default_nettype none

module agenChecker (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       issue_i,
	input  wire logic                       stationIdle_i,
	input  wire agenTypesPkg::memRequest_t  expReq_i,
	input  wire logic                       expFast_i,
	input  wire logic                       reqValid_i,
	input  wire logic                       memReady_i,
	input  wire agenTypesPkg::memRequest_t  memRequest_i,
	output int                              checked_o,
	output int                              errors_o
);

	// Outstanding ops in issue order
	agenTypesPkg::memRequest_t expQ[$];
	int issueCycQ[$];
	logic fastQ[$];

	int cyc;
	logic rstQ;
	logic stallQ;
	agenTypesPkg::memRequest_t heldReq;

	function automatic int checkField(string name, logic [31:0] expV, logic [31:0] actV);
		if (expV !== actV) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expV, actV);
			return 1;
		end
		return 0;
	endfunction

	always @(posedge clk) begin : watch
		agenTypesPkg::memRequest_t exp;
		int bad;
		int lat;
		if (rst) begin
			cyc = 0;
			rstQ = 1'b1;
			stallQ = 1'b0;
			checked_o = 0;
			errors_o = 0;
		end else begin
			cyc++;
			// First edge out of reset
			if (rstQ) begin
				bad = checkField("reqValid_o", 0, reqValid_i);
				bad += checkField("stationIdle_o", 1, stationIdle_i);
				errors_o += bad;
				$display("test reset state: %s", bad == 0 ? "ok" : "bad");
			end
			rstQ = 1'b0;
			// A stalled request must still be there and unchanged
			if (stallQ) begin
				if (!reqValid_i) begin
					$display("Request was withdrawn while memory was not ready at %0t", $time);
					errors_o++;
				end else if (memRequest_i !== heldReq) begin
					$display("[ERROR] %0t memRequest_o expected %h actual %h",
						$time, heldReq, memRequest_i);
					errors_o++;
				end
			end
			stallQ = reqValid_i && !memReady_i;
			heldReq = memRequest_i;
			// One op in the unit and one in the station leaves no room
			if (expQ.size() >= 2 && stationIdle_i) begin
				$display("Station reported idle with two ops in flight at %0t", $time);
				errors_o++;
			end
			if (reqValid_i && memReady_i) begin
				if (expQ.size() == 0) begin
					$display("Request accepted with no op outstanding at %0t", $time);
					errors_o++;
				end else begin
					exp = expQ.pop_front();
					lat = cyc - issueCycQ.pop_front() - 1;
					bad = checkField("memRequest_o.robNdx", exp.robNdx, memRequest_i.robNdx);
					bad += checkField("memRequest_o.memOp", exp.memOp, memRequest_i.memOp);
					bad += checkField("memRequest_o.address", exp.address, memRequest_i.address);
					bad += checkField("memRequest_o.storeData", exp.storeData,
						memRequest_i.storeData);
					bad += checkField("memRequest_o.dest", exp.dest, memRequest_i.dest);
					// Ready operands and a ready memory give a fixed latency
					if (fastQ.pop_front())
						bad += checkField("reqValid_o latency", 2, lat);
					errors_o += bad;
					checked_o++;
					$display("test op rob %0d: %s", exp.robNdx, bad == 0 ? "ok" : "bad");
				end
			end
			if (issue_i && stationIdle_i) begin
				expQ.push_back(expReq_i);
				issueCycQ.push_back(cyc);
				fastQ.push_back(expFast_i);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/agenTop.sv
// ================================================
// Address-generation top level
// Reservation station feeding the address unit
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "agen_config.svh"

module agenTop (
	input  wire logic                                              clk,
	input  wire logic                                              rst,
	input  wire logic                                              issue_i,
	input  wire agenTypesPkg::issueBundle_t                        issueBundle_i,
	input  wire agenTypesPkg::snoopPort_t [`AGEN_SNOOP_PORTS-1:0]  snoop_i,
	input  wire logic                                              memReady_i,
	output logic                                                   stationIdle_o,
	output logic                                                   reqValid_o,
	output agenTypesPkg::memRequest_t                              memRequest_o
);

	// ================================================
	// Station to unit
	// ================================================

	// Resolved operands offered to the adder
	logic opsValid;
	agenTypesPkg::agenOperands_t agenOperands;

	// Pulses when the adder latches, which frees the station
	logic opTaken;

	agenStation u_station (
		.clk            (clk),
		.rst            (rst),
		.issue_i        (issue_i),
		.issueBundle_i  (issueBundle_i),
		.snoop_i        (snoop_i),
		.opTaken_i      (opTaken),
		.stationIdle_o  (stationIdle_o),
		.opsValid_o     (opsValid),
		.agenOperands_o (agenOperands)
	);

	// ================================================
	// Address unit
	// ================================================

	// Under back-pressure one op waits here and the next waits in the station
	agenUnit u_unit (
		.clk            (clk),
		.rst            (rst),
		.opsValid_i     (opsValid),
		.agenOperands_i (agenOperands),
		.memReady_i     (memReady_i),
		.opTaken_o      (opTaken),
		.reqValid_o     (reqValid_o),
		.memRequest_o   (memRequest_o)
	);

endmodule

`default_nettype wire

//--- verilog/agenUnit.sv
// ================================================
// Address-generation unit
// Adds base, scaled index and immediate, then holds
// the memory request until the memory side takes it
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "agen_config.svh"

module agenUnit (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          opsValid_i,
	input  wire agenTypesPkg::agenOperands_t   agenOperands_i,
	input  wire logic                          memReady_i,
	output logic                               opTaken_o,
	output logic                               reqValid_o,
	output agenTypesPkg::memRequest_t          memRequest_o
);

	cpuTypesPkg::address_t immExt;
	cpuTypesPkg::address_t baseAddr;
	cpuTypesPkg::address_t indexAddr;
	agenTypesPkg::memRequest_t reqNext;
	agenTypesPkg::memRequest_t reqQ;
	logic reqValidQ;

	// ================================================
	// Address adder
	// ================================================

	always_comb begin
		// The 12-bit immediate is signed
		immExt = {{(`AGEN_ADDR_W - 12){agenOperands_i.imm[11]}}, agenOperands_i.imm};
		baseAddr = cpuTypesPkg::address_t'(agenOperands_i.aValue);
		indexAddr = cpuTypesPkg::address_t'(agenOperands_i.bValue) << agenOperands_i.scale;

		reqNext.robNdx = agenOperands_i.robNdx;
		reqNext.memOp = agenOperands_i.memOp;
		// Carries out of the top bit are dropped
		reqNext.address = baseAddr + indexAddr + immExt;
		reqNext.dest = agenOperands_i.dest;
		// Loads carry no data to memory
		if (agenOperands_i.memOp == agenTypesPkg::MEM_LOAD)
			reqNext.storeData = '0;
		else
			reqNext.storeData = agenOperands_i.cValue;
	end

	// ================================================
	// Request register
	// ================================================

	// Take a new op when the register is empty or is being emptied this cycle
	assign opTaken_o = opsValid_i && (!reqValidQ || memReady_i);

	always_ff @(posedge clk) begin
		if (rst)
			reqValidQ <= 1'b0;
		else if (opTaken_o)
			reqValidQ <= 1'b1;
		else if (memReady_i)
			reqValidQ <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (opTaken_o)
			reqQ <= reqNext;
	end

	assign reqValid_o = reqValidQ;
	assign memRequest_o = reqQ;

	// A stalled request may neither change nor vanish
	aReqHeld: assert property (@(posedge clk) disable iff (rst)
		reqValid_o && !memReady_i |=> reqValid_o && $stable(memRequest_o));

endmodule

`default_nettype wire

//--- verilog/agenStation.sv
// ================================================
// Address-generation reservation station
// Holds one issued memory op and snoops the result
// ports until base, index and store data are known
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "agen_config.svh"

module agenStation (
	input  wire logic                                              clk,
	input  wire logic                                              rst,
	input  wire logic                                              issue_i,
	input  wire agenTypesPkg::issueBundle_t                        issueBundle_i,
	input  wire agenTypesPkg::snoopPort_t [`AGEN_SNOOP_PORTS-1:0]  snoop_i,
	input  wire logic                                              opTaken_i,
	output logic                                                   stationIdle_o,
	output logic                                                   opsValid_o,
	output agenTypesPkg::agenOperands_t                            agenOperands_o
);

	// Control state
	logic busyQ;
	logic opsValidQ;
	logic [2:0] validQ;

	// Captured op where operand index 0 is A, 1 is B and 2 is C
	cpuTypesPkg::pregno_t [2:0] pregQ;
	cpuTypesPkg::value_t [2:0] valQ;
	cpuTypesPkg::robNdx_t robNdxQ;
	agenTypesPkg::memOp_t memOpQ;
	logic [1:0] scaleQ;
	logic [11:0] immQ;
	cpuTypesPkg::pregno_t destQ;

	// Issue operands gathered into an indexable form
	agenTypesPkg::srcOperand_t [2:0] srcIn;
	logic [2:0] snoopHit;
	cpuTypesPkg::value_t [2:0] snoopVal;
	logic issueTake;

	assign srcIn = {issueBundle_i.srcC, issueBundle_i.srcB, issueBundle_i.srcA};

	// A new op is only accepted into an empty station
	assign issueTake = issue_i && !busyQ;

	// ================================================
	// Snoop match
	// ================================================

	// Scan every result port for the wanted register
	// The scan runs from the top so the lowest matching port is written last and wins
	task automatic tSnoopMatch(
		input  cpuTypesPkg::pregno_t                               pReg,
		input  agenTypesPkg::snoopPort_t [`AGEN_SNOOP_PORTS-1:0]   ports,
		output logic                                               hit,
		output cpuTypesPkg::value_t                                val
	);
		int nn;
		hit = 1'b0;
		val = '0;
		for (nn = `AGEN_SNOOP_PORTS - 1; nn >= 0; nn--) begin
			if (ports[nn].valid && ports[nn].preg == pReg) begin
				hit = 1'b1;
				val = ports[nn].value;
			end
		end
	endtask

	always_comb begin
		for (int nn = 0; nn < 3; nn++) begin
			tSnoopMatch(pregQ[nn], snoop_i, snoopHit[nn], snoopVal[nn]);
		end
	end

	// ================================================
	// Control
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			busyQ <= 1'b0;
			validQ <= 3'b000;
			opsValidQ <= 1'b0;
		end else if (opTaken_i) begin
			// The unit has the operands, so the slot is free next cycle
			busyQ <= 1'b0;
			validQ <= 3'b000;
			opsValidQ <= 1'b0;
		end else if (issueTake) begin
			busyQ <= 1'b1;
			opsValidQ <= 1'b0;
			for (int nn = 0; nn < 3; nn++) begin
				// Register 0 needs no producer
				validQ[nn] <= srcIn[nn].ready || (srcIn[nn].preg == '0);
			end
		end else if (busyQ) begin
			validQ <= validQ | snoopHit;
			// Operands handed on one cycle after the last one arrives
			opsValidQ <= &validQ;
		end
	end

	// Captured op fields and operand values
	always_ff @(posedge clk) begin
		if (issueTake) begin
			robNdxQ <= issueBundle_i.robNdx;
			memOpQ <= issueBundle_i.memOp;
			scaleQ <= issueBundle_i.scale;
			immQ <= issueBundle_i.imm;
			destQ <= issueBundle_i.dest;
			for (int nn = 0; nn < 3; nn++) begin
				pregQ[nn] <= srcIn[nn].preg;
				if (srcIn[nn].preg == '0 || !srcIn[nn].ready)
					valQ[nn] <= '0;
				else
					valQ[nn] <= srcIn[nn].value;
			end
		end else if (busyQ) begin
			for (int nn = 0; nn < 3; nn++) begin
				if (!validQ[nn] && snoopHit[nn])
					valQ[nn] <= snoopVal[nn];
			end
		end
	end

	// ================================================
	// Outputs
	// ================================================

	assign stationIdle_o = !busyQ;
	assign opsValid_o = opsValidQ;

	always_comb begin
		agenOperands_o.robNdx = robNdxQ;
		agenOperands_o.memOp = memOpQ;
		agenOperands_o.aValue = valQ[0];
		agenOperands_o.bValue = valQ[1];
		agenOperands_o.cValue = valQ[2];
		agenOperands_o.scale = scaleQ;
		agenOperands_o.imm = immQ;
		agenOperands_o.dest = destQ;
	end

	// An issue while an op is still held would be lost
	aNoIssueWhileBusy: assert property (@(posedge clk) disable iff (rst)
		issue_i |-> !busyQ);

	// The unit only ever sees operands that have all been resolved
	aOpsValidComplete: assert property (@(posedge clk) disable iff (rst)
		$rose(opsValid_o) |-> &validQ);

endmodule

`default_nettype wire

//--- verilog/agenTypesPkg.sv
// ================================================
// Address-generation bundles
// Issue, snoop and memory request structures for
// the station and the address unit
// ================================================
`default_nettype none

package agenTypesPkg;

	// Kind of memory micro-op
	// Code 2'b11 is not issued
	typedef enum logic [1:0] {
		MEM_LOAD   = 2'b00,
		MEM_STORE  = 2'b01,
		MEM_ATOMIC = 2'b10
	} memOp_t;

	// One source operand as it leaves rename
	// The value only means something when ready is set
	typedef struct packed {
		cpuTypesPkg::pregno_t preg;
		logic                 ready;
		cpuTypesPkg::value_t  value;
	} srcOperand_t;

	// ================================================
	// Issue side
	// ================================================

	// Base (A), index (B) and store data (C), plus the address fields
	typedef struct packed {
		cpuTypesPkg::robNdx_t robNdx;
		memOp_t               memOp;
		srcOperand_t          srcA;
		srcOperand_t          srcB;
		srcOperand_t          srcC;
		logic [1:0]           scale;
		logic [11:0]          imm;
		cpuTypesPkg::pregno_t dest;
	} issueBundle_t;

	// One result port of the register file or a functional unit
	typedef struct packed {
		logic                 valid;
		cpuTypesPkg::pregno_t preg;
		cpuTypesPkg::value_t  value;
	} snoopPort_t;

	// ================================================
	// Station to unit and unit to memory
	// ================================================

	// All operand values are resolved by the time this is presented
	typedef struct packed {
		cpuTypesPkg::robNdx_t robNdx;
		memOp_t               memOp;
		cpuTypesPkg::value_t  aValue;
		cpuTypesPkg::value_t  bValue;
		cpuTypesPkg::value_t  cValue;
		logic [1:0]           scale;
		logic [11:0]          imm;
		cpuTypesPkg::pregno_t dest;
	} agenOperands_t;

	// Request presented to the memory side
	typedef struct packed {
		cpuTypesPkg::robNdx_t   robNdx;
		memOp_t                 memOp;
		cpuTypesPkg::address_t  address;
		cpuTypesPkg::value_t    storeData;
		cpuTypesPkg::pregno_t   dest;
	} memRequest_t;

endpackage

`default_nettype wire

//--- verilog/cpuTypesPkg.sv
// ================================================
// CPU back-end core types
// Register values, addresses and the tags that
// follow an op through the back end
// ================================================
`default_nettype none

`include "agen_config.svh"

package cpuTypesPkg;

	// A general register value as read from the register file
	typedef logic [31:0] value_t;

	// A memory address as seen by the load/store path
	// It may be narrower or wider than a register value
	typedef logic [`AGEN_ADDR_W-1:0] address_t;

	// A physical register number after rename
	// Number 0 never gets written and always reads as zero
	typedef logic [`AGEN_PREG_W-1:0] pregno_t;

	// Reorder buffer slot that owns an op
	// The memory side hands this back on completion
	typedef logic [4:0] robNdx_t;

endpackage

`default_nettype wire

//--- include/agen_config.svh
// ================================================
// Address-generation station build parameters
// Sizes the snoop bus, the address and the physical
// register number used across the back end
// ================================================
`ifndef AGEN_CONFIG_SVH
`define AGEN_CONFIG_SVH

// Number of register-file and result ports the station watches
`define AGEN_SNOOP_PORTS 4

// Width of a generated memory address
// Sums wider than this wrap around
`define AGEN_ADDR_W 32

// Width of a physical register number
// Register 0 is hardwired to read as zero
`define AGEN_PREG_W 7

`endif
